// ==== include/cpu_params.svh ====
// Core widths, register count, reset PC and link register
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data path and address width
`define DATA_W 16

`define REG_CNT 8

// First fetch address after reset
`define RESET_PC 16'h0000

// jal and jalr write their return address here
`define LINK_REG 3'd7

`endif

// ==== hw/isaPkg.sv ====
// Opcode enumeration and instruction word formats
package isaPkg;

	typedef enum logic [4:0] {
		opHalt   = 5'b00000,
		opNop    = 5'b00001,
		opJ      = 5'b00100,
		opJr     = 5'b00101,
		opJal    = 5'b00110,
		opJalr   = 5'b00111,
		opAddi   = 5'b01000,
		opSubi   = 5'b01001,
		opXori   = 5'b01010,
		opAndi   = 5'b01011,
		opBeqz   = 5'b01100,
		opBnez   = 5'b01101,
		opBltz   = 5'b01110,
		opBgez   = 5'b01111,
		opSt     = 5'b10000,
		opLd     = 5'b10001,
		opSlbi   = 5'b10010,
		opStu    = 5'b10011,
		opRoli   = 5'b10100,
		opSlli   = 5'b10101,
		opRori   = 5'b10110,
		opSrli   = 5'b10111,
		opLbi    = 5'b11000,
		opShiftR = 5'b11010,
		opArithR = 5'b11011,
		opSeq    = 5'b11100,
		opSlt    = 5'b11101,
		opSle    = 5'b11110,
		opSco    = 5'b11111
	} opcodeT;

	// Immediate ops, loads and stores with a 5-bit immediate
	typedef struct packed {
		opcodeT     op;
		logic [2:0] rs;
		logic [2:0] rd;
		logic [4:0] imm5;
	} i1FmtT;

	// lbi, slbi, branches, jr and jalr
	typedef struct packed {
		opcodeT     op;
		logic [2:0] rs;
		logic [7:0] imm8;
	} i2FmtT;

	typedef struct packed {
		opcodeT     op;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [1:0] func;
	} rFmtT;

	typedef struct packed {
		opcodeT      op;
		logic [10:0] disp11;
	} jFmtT;

	typedef union packed {
		i1FmtT i1;
		i2FmtT i2;
		rFmtT  r;
		jFmtT  j;
	} instrU;

endpackage

// ==== hw/ctrlPkg.sv ====
// ALU operations, datapath selectors, control word and commit record
`include "cpu_params.svh"

package ctrlPkg;

	typedef enum logic [3:0] {
		aluAdd, aluSubRev, aluXor, aluAndn,
		aluRol, aluSll, aluRor, aluSrl,
		aluPassB, aluSlbi,
		aluSeq, aluSlt, aluSle, aluSco
	} aluOpT;

	typedef enum logic [1:0] {immZext5, immSext5, immSext8, immZext8} immSelT;

	typedef enum logic [1:0] {dstRdI, dstRdR, dstRs, dstLink} dstSelT;

	typedef enum logic [1:0] {wbAlu, wbMem, wbPc2} wbSelT;

	typedef struct packed {
		logic       regWrite;
		logic       aluSrc;
		aluOpT      aluOp;
		immSelT     immSel;
		dstSelT     dstSel;
		wbSelT      wbSel;
		logic       memWrite;
		logic       memRead;
		logic       branch;
		logic [1:0] branchCond;  // eq, ne, lt, ge against zero
		logic       jump;
		logic       jumpReg;
		logic       halt;
	} ctrlT;

	typedef struct packed {
		logic                        regWrite;
		logic [$clog2(`REG_CNT)-1:0] wbReg;
		logic [`DATA_W-1:0]          wbData;
	} commitT;

endpackage

// ==== hw/control.sv ====
// Instruction decoder producing the control word
`timescale 1ns/100ps

module control (
	input  isaPkg::instrU instr,
	output ctrlPkg::ctrlT ctrl
);

	// Same func order for the add group and the immediate arithmetic ops
	function automatic ctrlPkg::aluOpT arithOp(input logic [1:0] sel);
		case (sel)
			2'b00:   return ctrlPkg::aluAdd;
			2'b01:   return ctrlPkg::aluSubRev;
			2'b10:   return ctrlPkg::aluXor;
			default: return ctrlPkg::aluAndn;
		endcase
	endfunction

	function automatic ctrlPkg::aluOpT shiftOp(input logic [1:0] sel);
		case (sel)
			2'b00:   return ctrlPkg::aluRol;
			2'b01:   return ctrlPkg::aluSll;
			2'b10:   return ctrlPkg::aluRor;
			default: return ctrlPkg::aluSrl;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		case (instr.r.op)
			isaPkg::opHalt: ctrl.halt = 1'b1;
			isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori, isaPkg::opAndi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = arithOp(instr[12:11]);
				// Logic immediates are zero extended
				ctrl.immSel = instr[12] ? ctrlPkg::immZext5 : ctrlPkg::immSext5;
			end
			isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = shiftOp(instr[12:11]);
				ctrl.immSel = ctrlPkg::immSext5;
			end
			isaPkg::opSt, isaPkg::opLd, isaPkg::opStu: begin
				ctrl.aluSrc = 1'b1;
				ctrl.immSel = ctrlPkg::immSext5;
				ctrl.memWrite = instr.r.op != isaPkg::opLd;
				ctrl.memRead = instr.r.op == isaPkg::opLd;
				ctrl.regWrite = instr.r.op != isaPkg::opSt;
				// stu writes the effective address back to rs
				ctrl.dstSel = instr.r.op == isaPkg::opStu ? ctrlPkg::dstRs : ctrlPkg::dstRdI;
				ctrl.wbSel = instr.r.op == isaPkg::opLd ? ctrlPkg::wbMem : ctrlPkg::wbAlu;
			end
			isaPkg::opLbi, isaPkg::opSlbi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.dstSel = ctrlPkg::dstRs;
				if (instr.r.op == isaPkg::opLbi) begin
					ctrl.aluOp = ctrlPkg::aluPassB;
					ctrl.immSel = ctrlPkg::immSext8;
				end else begin
					ctrl.aluOp = ctrlPkg::aluSlbi;
					ctrl.immSel = ctrlPkg::immZext8;
				end
			end
			isaPkg::opArithR, isaPkg::opShiftR: begin
				ctrl.regWrite = 1'b1;
				ctrl.dstSel = ctrlPkg::dstRdR;
				ctrl.aluOp = instr[11] ? arithOp(instr.r.func) : shiftOp(instr.r.func);
			end
			isaPkg::opSeq, isaPkg::opSlt, isaPkg::opSle, isaPkg::opSco: begin
				ctrl.regWrite = 1'b1;
				ctrl.dstSel = ctrlPkg::dstRdR;
				case (instr[12:11])
					2'b00:   ctrl.aluOp = ctrlPkg::aluSeq;
					2'b01:   ctrl.aluOp = ctrlPkg::aluSlt;
					2'b10:   ctrl.aluOp = ctrlPkg::aluSle;
					default: ctrl.aluOp = ctrlPkg::aluSco;
				endcase
			end
			isaPkg::opBeqz, isaPkg::opBnez, isaPkg::opBltz, isaPkg::opBgez: begin
				ctrl.branch = 1'b1;
				// Low opcode bits already encode the condition
				ctrl.branchCond = instr[12:11];
			end
			isaPkg::opJ, isaPkg::opJal, isaPkg::opJr, isaPkg::opJalr: begin
				ctrl.jump = 1'b1;
				ctrl.jumpReg = instr[11];
				ctrl.aluSrc = 1'b1;
				ctrl.immSel = ctrlPkg::immSext8;
				// jal and jalr link through R7
				ctrl.regWrite = instr[12];
				ctrl.dstSel = ctrlPkg::dstLink;
				ctrl.wbSel = ctrlPkg::wbPc2;
			end
			// nop, siic, rti, btr and unknown opcodes
			default: ;
		endcase
	end

endmodule

// ==== hw/regFile.sv ====
// Register file with two read ports and one write port
`timescale 1ns/100ps
`include "cpu_params.svh"

module regFile (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic [$clog2(`REG_CNT)-1:0] rs,
	input  logic [$clog2(`REG_CNT)-1:0] rt,
	output logic [`DATA_W-1:0]          rsData,
	output logic [`DATA_W-1:0]          rtData,
	input  ctrlPkg::commitT             commit
);

	logic [`DATA_W-1:0] regs [`REG_CNT];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regs <= '{default: '0};
		end else if (commit.regWrite) begin
			regs[commit.wbReg] <= commit.wbData;
		end
	end

	// Reads see the old value during a write cycle
	assign rsData = regs[rs];
	assign rtData = regs[rt];

endmodule

// ==== hw/alu.sv ====
// Immediate extension, operand select and ALU result
`timescale 1ns/100ps
`include "cpu_params.svh"

module alu (
	input  ctrlPkg::ctrlT      ctrl,
	input  isaPkg::instrU      instr,
	input  logic [`DATA_W-1:0] rsData,
	input  logic [`DATA_W-1:0] rtData,
	output logic [`DATA_W-1:0] result
);

	logic [`DATA_W-1:0]   imm;
	logic [`DATA_W-1:0]   opB;
	logic [3:0]           amt;
	logic [`DATA_W:0]     sum;
	logic [2*`DATA_W-1:0] rolWide;
	logic [2*`DATA_W-1:0] rorWide;
	logic                 setBit;

	always_comb begin
		case (ctrl.immSel)
			ctrlPkg::immZext5: imm = {11'b0, instr.i1.imm5};
			ctrlPkg::immSext5: imm = {{11{instr.i1.imm5[4]}}, instr.i1.imm5};
			ctrlPkg::immSext8: imm = {{8{instr.i2.imm8[7]}}, instr.i2.imm8};
			default:           imm = {8'b0, instr.i2.imm8};
		endcase
	end

	assign opB = ctrl.aluSrc ? imm : rtData;
	assign amt = opB[3:0];
	// Carry out feeds sco
	assign sum = {1'b0, rsData} + {1'b0, opB};
	assign rolWide = {rsData, rsData} << amt;
	assign rorWide = {rsData, rsData} >> amt;

	always_comb begin
		case (ctrl.aluOp)
			ctrlPkg::aluSeq: setBit = rsData == opB;
			ctrlPkg::aluSlt: setBit = $signed(rsData) < $signed(opB);
			ctrlPkg::aluSle: setBit = $signed(rsData) <= $signed(opB);
			default:         setBit = sum[`DATA_W];
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			ctrlPkg::aluAdd:    result = sum[`DATA_W-1:0];
			ctrlPkg::aluSubRev: result = opB - rsData;
			ctrlPkg::aluXor:    result = rsData ^ opB;
			// andi takes the immediate as is
			ctrlPkg::aluAndn:   result = ctrl.aluSrc ? rsData & opB : rsData & ~opB;
			ctrlPkg::aluRol:    result = rolWide[2*`DATA_W-1:`DATA_W];
			ctrlPkg::aluSll:    result = rsData << amt;
			ctrlPkg::aluRor:    result = rorWide[`DATA_W-1:0];
			ctrlPkg::aluSrl:    result = rsData >> amt;
			ctrlPkg::aluPassB:  result = opB;
			ctrlPkg::aluSlbi:   result = (rsData << 8) | opB;
			ctrlPkg::aluSeq, ctrlPkg::aluSlt, ctrlPkg::aluSle, ctrlPkg::aluSco:
				result = {{(`DATA_W-1){1'b0}}, setBit};
			default:            result = '0;
		endcase
	end

endmodule

// ==== hw/pcUnit.sv ====
// Program counter, halt latch and next-PC selection
`timescale 1ns/100ps
`include "cpu_params.svh"

module pcUnit (
	input  logic               clk,
	input  logic               arstN,
	input  ctrlPkg::ctrlT      ctrl,
	input  isaPkg::instrU      instr,
	input  logic [`DATA_W-1:0] rsData,
	input  logic [`DATA_W-1:0] aluResult,
	output logic [`DATA_W-1:0] pc,
	output logic [`DATA_W-1:0] pcPlus2,
	output logic               halted
);

	logic               taken;
	logic [`DATA_W-1:0] brOffset;
	logic [`DATA_W-1:0] jOffset;
	logic [`DATA_W-1:0] nextPc;

	assign pcPlus2 = pc + `DATA_W'(2);
	assign brOffset = {{8{instr.i2.imm8[7]}}, instr.i2.imm8};
	assign jOffset = {{5{instr.j.disp11[10]}}, instr.j.disp11};

	always_comb begin
		case (ctrl.branchCond)
			2'b00:   taken = rsData == '0;
			2'b01:   taken = rsData != '0;
			2'b10:   taken = rsData[`DATA_W-1];
			default: taken = !rsData[`DATA_W-1];
		endcase
	end

	always_comb begin
		if (ctrl.jump && ctrl.jumpReg)
			nextPc = aluResult;
		else if (ctrl.jump)
			nextPc = pcPlus2 + jOffset;
		else if (ctrl.branch && taken)
			nextPc = pcPlus2 + brOffset;
		else
			nextPc = pcPlus2;
	end

	// PC stays on the halt instruction
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= `RESET_PC;
			halted <= 1'b0;
		end else if (!halted) begin
			if (ctrl.halt)
				halted <= 1'b1;
			else
				pc <= nextPc;
		end
	end

endmodule

// ==== hw/cpuCore.sv ====
// Single-cycle core top level with instruction and data memory buses
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpuCore (
	input  logic               clk,
	input  logic               arstN,
	output logic [`DATA_W-1:0] pc,
	input  isaPkg::instrU      instr,
	output logic [`DATA_W-1:0] dmemAddr,
	output logic [`DATA_W-1:0] dmemWdata,
	output logic               dmemWrite,
	output logic               dmemRead,
	input  logic [`DATA_W-1:0] dmemRdata,
	output ctrlPkg::commitT    commit,
	output logic               halted
);

	ctrlPkg::ctrlT      ctrl;
	logic [`DATA_W-1:0] rsData;
	logic [`DATA_W-1:0] rtData;
	logic [`DATA_W-1:0] aluResult;
	logic [`DATA_W-1:0] pcPlus2;

	control uControl (.instr(instr), .ctrl(ctrl));

	regFile uRegFile (
		.clk(clk), .arstN(arstN), .rs(instr.r.rs), .rt(instr.r.rt),
		.rsData(rsData), .rtData(rtData), .commit(commit)
	);

	alu uAlu (.ctrl(ctrl), .instr(instr), .rsData(rsData), .rtData(rtData), .result(aluResult));

	pcUnit uPcUnit (
		.clk(clk), .arstN(arstN), .ctrl(ctrl), .instr(instr), .rsData(rsData),
		.aluResult(aluResult), .pc(pc), .pcPlus2(pcPlus2), .halted(halted)
	);

	// Store data comes from rd, read on the rt port
	assign dmemAddr = aluResult;
	assign dmemWdata = rtData;
	assign dmemWrite = ctrl.memWrite && !halted;
	assign dmemRead = ctrl.memRead && !halted;

	always_comb begin
		commit.regWrite = ctrl.regWrite && !halted;
		case (ctrl.dstSel)
			ctrlPkg::dstRdI: commit.wbReg = instr.i1.rd;
			ctrlPkg::dstRdR: commit.wbReg = instr.r.rd;
			ctrlPkg::dstRs:  commit.wbReg = instr.r.rs;
			default:         commit.wbReg = `LINK_REG;
		endcase
		case (ctrl.wbSel)
			ctrlPkg::wbMem: commit.wbData = dmemRdata;
			ctrlPkg::wbPc2: commit.wbData = pcPlus2;
			default:        commit.wbData = aluResult;
		endcase
	end

endmodule

// ==== test/cpuTb.sv ====
// Testbench for cpuCore with instruction table, data memory model, LCG and compare tasks
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpuTb;

	typedef struct packed {
		logic [`DATA_W-1:0] instr;
		ctrlPkg::commitT    commit;
		logic [`DATA_W-1:0] nextPc;
		logic               memWrite;
		logic               memRead;
		logic [`DATA_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} rowT;

	logic               clk;
	logic               arstN;
	isaPkg::instrU      instr;
	logic [`DATA_W-1:0] pc;
	logic [`DATA_W-1:0] dmemAddr;
	logic [`DATA_W-1:0] dmemWdata;
	logic [`DATA_W-1:0] dmemRdata;
	logic               dmemWrite;
	logic               dmemRead;
	ctrlPkg::commitT    commit;
	logic               halted;

	logic [`DATA_W-1:0] dmem [0:65535];
	rowT                rows[$];
	logic [`DATA_W-1:0] bpc;

	cpuCore uut (
		.clk(clk), .arstN(arstN), .pc(pc), .instr(instr), .dmemAddr(dmemAddr),
		.dmemWdata(dmemWdata), .dmemWrite(dmemWrite), .dmemRead(dmemRead),
		.dmemRdata(dmemRdata), .commit(commit), .halted(halted)
	);

	always #5 clk = ~clk;

	// Combinational data memory reads and clocked stores
	assign dmemRdata = dmem[dmemAddr];
	always @(posedge clk) begin
		if (dmemWrite)
			dmem[dmemAddr] <= dmemWdata;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [15:0] encodeI1(input isaPkg::opcodeT op, input logic [2:0] rs,
		input logic [2:0] rd, input logic [4:0] imm5);
		return {op, rs, rd, imm5};
	endfunction

	function automatic logic [15:0] encodeI2(input isaPkg::opcodeT op, input logic [2:0] rs,
		input logic [7:0] imm8);
		return {op, rs, imm8};
	endfunction

	function automatic logic [15:0] encodeR(input isaPkg::opcodeT op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] func);
		return {op, rs, rt, rd, func};
	endfunction

	function automatic logic [15:0] encodeJ(input isaPkg::opcodeT op, input logic [10:0] disp);
		return {op, disp};
	endfunction

	task automatic stopWithFailure();
		$display("sim failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkWord(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkBit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
			stopWithFailure();
		end
	endtask

	// Register and data only matter when a write is expected
	task automatic checkCommit(input ctrlPkg::commitT got, input ctrlPkg::commitT exp,
		input int row);
		if (got.regWrite !== exp.regWrite || (exp.regWrite &&
			(got.wbReg !== exp.wbReg || got.wbData !== exp.wbData))) begin
			$display("[FAIL] %0t: row %0d commit is we=%b r%0d=%h, expected we=%b r%0d=%h",
				$time, row, got.regWrite, got.wbReg, got.wbData,
				exp.regWrite, exp.wbReg, exp.wbData);
			stopWithFailure();
		end
	endtask

	task automatic pushRow(input logic [15:0] ins, input logic rw, input logic [2:0] rd,
		input logic [15:0] wd, input logic [15:0] nxt, input logic mw, input logic mr,
		input logic [15:0] addr, input logic [15:0] wdata);
		rowT r;
		r.instr = ins;
		r.commit.regWrite = rw;
		r.commit.wbReg = rd;
		r.commit.wbData = wd;
		r.nextPc = nxt;
		r.memWrite = mw;
		r.memRead = mr;
		r.addr = addr;
		r.wdata = wdata;
		rows.push_back(r);
		bpc = nxt;
	endtask

	task automatic regRow(input logic [15:0] ins, input logic [2:0] rd, input logic [15:0] wd);
		pushRow(ins, 1'b1, rd, wd, bpc + 16'd2, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic flowRow(input logic [15:0] ins, input logic [15:0] nxt);
		pushRow(ins, 1'b0, 3'd0, '0, nxt, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic buildTable();
		bpc = `RESET_PC;
		// Immediate forms
		regRow(encodeI2(isaPkg::opLbi, 3'd1, 8'h85), 3'd1, 16'hFF85);
		regRow(encodeI2(isaPkg::opSlbi, 3'd1, 8'h3C), 3'd1, 16'h853C);
		regRow(encodeI2(isaPkg::opLbi, 3'd2, 8'h12), 3'd2, 16'h0012);
		regRow(encodeI1(isaPkg::opAddi, 3'd1, 3'd3, 5'h1E), 3'd3, 16'h853A);
		regRow(encodeI1(isaPkg::opSubi, 3'd2, 3'd4, 5'h03), 3'd4, 16'hFFF1);
		regRow(encodeI1(isaPkg::opXori, 3'd1, 3'd5, 5'h1F), 3'd5, 16'h8523);
		regRow(encodeI1(isaPkg::opAndi, 3'd1, 3'd6, 5'h1C), 3'd6, 16'h001C);
		regRow(encodeI1(isaPkg::opRoli, 3'd1, 3'd3, 5'h14), 3'd3, 16'h53C8);
		regRow(encodeI1(isaPkg::opSlli, 3'd1, 3'd4, 5'h03), 3'd4, 16'h29E0);
		regRow(encodeI1(isaPkg::opRori, 3'd1, 3'd5, 5'h08), 3'd5, 16'h3C85);
		regRow(encodeI1(isaPkg::opSrli, 3'd1, 3'd6, 5'h0C), 3'd6, 16'h0008);
		// R-format and set conditions
		regRow(encodeR(isaPkg::opArithR, 3'd1, 3'd2, 3'd3, 2'd0), 3'd3, 16'h854E);
		regRow(encodeR(isaPkg::opArithR, 3'd1, 3'd2, 3'd4, 2'd1), 3'd4, 16'h7AD6);
		regRow(encodeR(isaPkg::opArithR, 3'd1, 3'd2, 3'd5, 2'd2), 3'd5, 16'h852E);
		regRow(encodeR(isaPkg::opArithR, 3'd1, 3'd2, 3'd6, 2'd3), 3'd6, 16'h852C);
		regRow(encodeR(isaPkg::opShiftR, 3'd1, 3'd2, 3'd3, 2'd0), 3'd3, 16'h14F2);
		regRow(encodeR(isaPkg::opShiftR, 3'd1, 3'd2, 3'd4, 2'd1), 3'd4, 16'h14F0);
		regRow(encodeR(isaPkg::opShiftR, 3'd1, 3'd2, 3'd5, 2'd2), 3'd5, 16'h214F);
		regRow(encodeR(isaPkg::opShiftR, 3'd1, 3'd6, 3'd6, 2'd3), 3'd6, 16'h0008);
		regRow(encodeR(isaPkg::opSeq, 3'd1, 3'd1, 3'd3, 2'd0), 3'd3, 16'h0001);
		regRow(encodeR(isaPkg::opSeq, 3'd1, 3'd2, 3'd3, 2'd0), 3'd3, 16'h0000);
		regRow(encodeR(isaPkg::opSlt, 3'd1, 3'd2, 3'd4, 2'd0), 3'd4, 16'h0001);
		regRow(encodeR(isaPkg::opSle, 3'd2, 3'd1, 3'd5, 2'd0), 3'd5, 16'h0000);
		regRow(encodeR(isaPkg::opSle, 3'd1, 3'd1, 3'd5, 2'd0), 3'd5, 16'h0001);
		regRow(encodeR(isaPkg::opSco, 3'd1, 3'd1, 3'd6, 2'd0), 3'd6, 16'h0001);
		regRow(encodeR(isaPkg::opSco, 3'd2, 3'd2, 3'd3, 2'd0), 3'd3, 16'h0000);
		// Memory with one ld from the preloaded words
		pushRow(encodeI1(isaPkg::opSt, 3'd2, 3'd1, 5'h02), 1'b0, 3'd0, '0, bpc + 16'd2,
			1'b1, 1'b0, 16'h0014, 16'h853C);
		pushRow(encodeI1(isaPkg::opLd, 3'd2, 3'd3, 5'h02), 1'b1, 3'd3, 16'h853C, bpc + 16'd2,
			1'b0, 1'b1, 16'h0014, '0);
		pushRow(encodeI1(isaPkg::opLd, 3'd1, 3'd4, 5'h10), 1'b1, 3'd4, dmem[16'h852C],
			bpc + 16'd2, 1'b0, 1'b1, 16'h852C, '0);
		pushRow(encodeI1(isaPkg::opStu, 3'd2, 3'd5, 5'h0E), 1'b1, 3'd2, 16'h0020, bpc + 16'd2,
			1'b1, 1'b0, 16'h0020, 16'h0001);
		pushRow(encodeI1(isaPkg::opLd, 3'd2, 3'd6, 5'h00), 1'b1, 3'd6, 16'h0001, bpc + 16'd2,
			1'b0, 1'b1, 16'h0020, '0);
		// Branches taken and not taken
		flowRow(encodeI2(isaPkg::opBeqz, 3'd0, 8'h04), bpc + 16'd6);
		flowRow(encodeI2(isaPkg::opBeqz, 3'd5, 8'h04), bpc + 16'd2);
		flowRow(encodeI2(isaPkg::opBnez, 3'd5, 8'hFC), bpc - 16'd2);
		flowRow(encodeI2(isaPkg::opBnez, 3'd0, 8'h06), bpc + 16'd2);
		flowRow(encodeI2(isaPkg::opBltz, 3'd1, 8'h02), bpc + 16'd4);
		flowRow(encodeI2(isaPkg::opBltz, 3'd2, 8'h02), bpc + 16'd2);
		flowRow(encodeI2(isaPkg::opBgez, 3'd2, 8'h10), bpc + 16'd18);
		flowRow(encodeI2(isaPkg::opBgez, 3'd1, 8'h10), bpc + 16'd2);
		// Jumps
		flowRow(encodeJ(isaPkg::opJ, 11'h7F0), bpc - 16'd14);
		flowRow(encodeI2(isaPkg::opJr, 3'd2, 8'h06), 16'h0026);
		pushRow(encodeJ(isaPkg::opJal, 11'h020), 1'b1, `LINK_REG, bpc + 16'd2, bpc + 16'h0022,
			1'b0, 1'b0, '0, '0);
		pushRow(encodeI2(isaPkg::opJalr, 3'd1, 8'hF0), 1'b1, `LINK_REG, bpc + 16'd2, 16'h852C,
			1'b0, 1'b0, '0, '0);
		// nop and left-out opcodes before halt
		flowRow(encodeI2(isaPkg::opNop, 3'd3, 8'h5A), bpc + 16'd2);
		flowRow(16'b00010_011_0101_1010, bpc + 16'd2);
		flowRow(16'b11001_001_010_011_01, bpc + 16'd2);
		flowRow(encodeI2(isaPkg::opHalt, 3'd0, 8'h00), bpc);
	endtask

	initial begin
		logic [31:0]        seed;
		logic [`DATA_W-1:0] curPc;
		logic [`DATA_W-1:0] haltPc;
		logic [15:0]        afterHalt [4];
		int                 waited;
		clk = 1'b0;
		arstN = 1'b0;
		instr = encodeI2(isaPkg::opNop, 3'd0, 8'h00);
		seed = 32'd83284;
		for (int a = 0; a < 65536; a++) begin
			seed = lcgNext(seed);
			dmem[a] = seed[31:16] ^ 16'(a);
		end
		buildTable();

		@(posedge clk);
		@(negedge clk);
		checkWord("pc in reset", pc, `RESET_PC);
		checkBit("halted in reset", halted, 1'b0);

		// Reset releases on the edge that presents the first row
		curPc = `RESET_PC;
		foreach (rows[i]) begin
			@(posedge clk);
			arstN <= 1'b1;
			instr <= rows[i].instr;
			@(negedge clk);
			checkWord($sformatf("row %0d pc", i), pc, curPc);
			checkBit($sformatf("row %0d halted", i), halted, 1'b0);
			checkCommit(commit, rows[i].commit, i);
			checkBit($sformatf("row %0d dmemWrite", i), dmemWrite, rows[i].memWrite);
			checkBit($sformatf("row %0d dmemRead", i), dmemRead, rows[i].memRead);
			if (rows[i].memWrite || rows[i].memRead)
				checkWord($sformatf("row %0d dmemAddr", i), dmemAddr, rows[i].addr);
			if (rows[i].memWrite)
				checkWord($sformatf("row %0d dmemWdata", i), dmemWdata, rows[i].wdata);
			curPc = rows[i].nextPc;
		end
		haltPc = curPc;

		waited = 0;
		while (!halted) begin
			if (waited >= 10) begin
				$display("Timeout: halted did not rise within 10 cycles of the halt instruction");
				stopWithFailure();
			end
			@(negedge clk);
			waited++;
		end

		// Nothing may retire or touch memory once halted
		afterHalt[0] = encodeI1(isaPkg::opSt, 3'd2, 3'd1, 5'h00);
		afterHalt[1] = encodeI1(isaPkg::opAddi, 3'd1, 3'd3, 5'h01);
		afterHalt[2] = encodeI1(isaPkg::opLd, 3'd2, 3'd6, 5'h00);
		afterHalt[3] = encodeJ(isaPkg::opJal, 11'h010);
		checkWord("pc after halt", pc, haltPc);
		for (int k = 0; k < 4; k++) begin
			@(posedge clk);
			instr <= afterHalt[k];
			@(negedge clk);
			checkWord("pc while halted", pc, haltPc);
			checkBit("halted while halted", halted, 1'b1);
			checkBit("commit while halted", commit.regWrite, 1'b0);
			checkBit("dmemWrite while halted", dmemWrite, 1'b0);
			checkBit("dmemRead while halted", dmemRead, 1'b0);
		end

		$display("sim passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/control.sv
hw/regFile.sv
hw/alu.sv
hw/pcUnit.sv
hw/cpuCore.sv
test/cpuTb.sv
